// ==== logic/chest_pkg.sv ====
package chest_pkg;

    // complex sample word, im in the upper half and re in the lower half
    localparam int SAMPLE_W = 32;
    localparam int IQ_W     = 16;

    // OFDM symbol layout
    localparam int FFT_LEN        = 256;
    localparam int SC_W           = $clog2(FFT_LEN);
    localparam int GUARD_SC       = 8;
    localparam int PILOTS_PER_SYM = 60;

    // PBCH DMRS: 144 QPSK symbols for each of the eight ibar_SSB candidates
    localparam int DMRS_LEN = 144;
    localparam int NUM_IBAR = 8;

    // length-31 Gold generator, x1 uses x^31 + x^3 + 1 and
    // x2 uses x^31 + x^3 + x^2 + x + 1
    localparam int GOLD_N      = 31;
    localparam int GOLD_NC     = 1600;
    localparam int GOLD_CNT_W  = 11;
    localparam logic [GOLD_N-1:0] X1_TAPS = 31'h0000_0009;
    localparam logic [GOLD_N-1:0] X2_TAPS = 31'h0000_000f;

    // two symbols of buffering for the sample stream
    localparam int FIFO_DEPTH = 512;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // two bit matches per pilot at most
    localparam int CORR_W = $clog2(2 * PILOTS_PER_SYM + 1);

    typedef logic [9:0] n_id_t;
    typedef logic [2:0] ibar_t;

    // bit 1 is the earlier sequence bit (real sign), bit 0 the later one (imaginary sign)
    typedef logic [1:0] dmrs_sym_t;
    typedef dmrs_sym_t [NUM_IBAR-1:0] dmrs_row_t;

    typedef logic [CORR_W-1:0] corr_t;

    typedef struct packed {
        logic signed [IQ_W-1:0] im;
        logic signed [IQ_W-1:0] re;
    } iq_t;

    typedef union packed {
        logic [SAMPLE_W-1:0] raw;
        iq_t                 iq;
    } sample_u;

    typedef struct packed {
        sample_u sample;
        logic    pbch_start;
    } stream_t;

    typedef struct packed {
        stream_t beat;
        ibar_t   ibar;
    } out_beat_t;

endpackage

// ==== logic/gold_lfsr.sv ====
module gold_lfsr #(
    parameter logic [chest_pkg::GOLD_N-1:0] TAPS = chest_pkg::X1_TAPS
) (
    input  logic                         clk_i,
    input  logic                         reset_ni,
    input  logic                         load_i,
    input  logic [chest_pkg::GOLD_N-1:0] init_i,
    input  logic                         shift_i,
    output logic                         bit_o
);
    import chest_pkg::*;

    // bit 0 holds x(n), bit GOLD_N-1 holds x(n+30)
    logic [GOLD_N-1:0] state_q;
    logic              feedback;

    assign feedback = ^(state_q & TAPS);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= '0;
        end else if (load_i) begin
            state_q <= init_i;
        end else if (shift_i) begin
            // new bit x(n+31) enters at the top, oldest bit falls out at the bottom
            state_q <= {feedback, state_q[GOLD_N-1:1]};
        end
    end

    assign bit_o = state_q[0];

endmodule

// ==== logic/pbch_dmrs_gen.sv ====
module pbch_dmrs_gen (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  chest_pkg::n_id_t     n_id_i,
    input  logic                 n_id_valid_i,
    input  logic [7:0]           rd_idx_i,
    output chest_pkg::dmrs_row_t row_o,
    output logic                 dmrs_ready_o,
    output logic [1:0]           v_o
);
    import chest_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_WARM,
        ST_FILL,
        ST_DONE
    } gen_state_t;

    gen_state_t              state_q;
    logic [GOLD_CNT_W-1:0]   cnt_q;
    n_id_t                   n_id_q;
    logic                    lfsr_load;
    logic                    lfsr_shift;
    logic                    x1_bit;
    logic [NUM_IBAR-1:0]     x2_bit;
    logic [NUM_IBAR-1:0]     seq_bit;
    logic [NUM_IBAR-1:0]     even_bit_q;
    dmrs_row_t               wr_row;
    dmrs_row_t               dmrs_mem_q [DMRS_LEN];

    // c_init = ((i+1)*(N_id/4+1) << 11) + ((i+1) << 6) + N_id mod 4
    function automatic logic [GOLD_N-1:0] x2_init(input int unsigned ibar, input n_id_t n_id);
        logic [GOLD_N-1:0] idx;
        logic [GOLD_N-1:0] grp;
        idx = GOLD_N'(ibar + 1);
        grp = GOLD_N'(n_id[9:2]) + GOLD_N'(1);
        return ((idx * grp) << 11) + (idx << 6) + GOLD_N'(n_id[1:0]);
    endfunction

    assign lfsr_load  = (state_q == ST_LOAD);
    assign lfsr_shift = (state_q == ST_WARM) || (state_q == ST_FILL);

    gold_lfsr #(
        .TAPS (X1_TAPS)
    ) i_x1 (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .load_i   (lfsr_load),
        .init_i   (GOLD_N'(1)),
        .shift_i  (lfsr_shift),
        .bit_o    (x1_bit)
    );

    for (genvar g = 0; g < NUM_IBAR; g++) begin : g_x2
        gold_lfsr #(
            .TAPS (X2_TAPS)
        ) i_x2 (
            .clk_i    (clk_i),
            .reset_ni (reset_ni),
            .load_i   (lfsr_load),
            .init_i   (x2_init(g, n_id_q)),
            .shift_i  (lfsr_shift),
            .bit_o    (x2_bit[g])
        );

        assign seq_bit[g] = x1_bit ^ x2_bit[g];
        // the earlier bit of the pair goes to bit 1
        assign wr_row[g]  = {even_bit_q[g], seq_bit[g]};
    end

    // a new cell identity restarts generation from any state
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            n_id_q  <= '0;
        end else if (n_id_valid_i) begin
            state_q <= ST_LOAD;
            n_id_q  <= n_id_i;
        end else begin
            case (state_q)
                ST_LOAD: begin
                    cnt_q   <= '0;
                    state_q <= ST_WARM;
                end
                ST_WARM: begin
                    if (cnt_q == GOLD_CNT_W'(GOLD_NC - 1)) begin
                        cnt_q   <= '0;
                        state_q <= ST_FILL;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ST_FILL: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == GOLD_CNT_W'(2 * DMRS_LEN - 1)) begin
                        state_q <= ST_DONE;
                    end
                end
                default: begin
                    state_q <= state_q;
                end
            endcase
        end
    end

    // even bits wait one cycle, odd bits complete a row
    always_ff @(posedge clk_i) begin
        if (state_q == ST_FILL) begin
            if (!cnt_q[0]) begin
                even_bit_q <= seq_bit;
            end else begin
                dmrs_mem_q[cnt_q[8:1]] <= wr_row;
            end
        end
    end

    assign row_o        = dmrs_mem_q[rd_idx_i];
    assign dmrs_ready_o = (state_q == ST_DONE);
    assign v_o          = n_id_q[1:0];

endmodule

// ==== logic/ibar_detector.sv ====
module ibar_detector (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  chest_pkg::stream_t   beat_i,
    input  logic                 beat_take_i,
    input  logic                 dmrs_ready_i,
    input  logic [1:0]           v_i,
    output logic [7:0]           rd_idx_o,
    input  chest_pkg::dmrs_row_t row_i,
    output chest_pkg::ibar_t     ibar_o,
    output logic                 ibar_valid_o
);
    import chest_pkg::*;

    logic            busy_q;
    logic [SC_W-1:0] sc_q;
    logic [7:0]      pilot_q;
    corr_t           corr_q [NUM_IBAR];
    ibar_t           ibar_q;
    logic            ibar_valid_q;
    logic            start;
    logic            last_sc;
    logic            is_pilot;
    logic            re_neg;
    logic            im_neg;
    ibar_t           best_idx;
    corr_t           best_corr;

    // the start beat is subcarrier 0 and never carries a pilot
    assign start   = beat_take_i && beat_i.pbch_start && dmrs_ready_i && !busy_q;
    assign last_sc = (sc_q == SC_W'(FFT_LEN - 1));

    assign is_pilot = (sc_q >= SC_W'(GUARD_SC))
                   && (sc_q < SC_W'(FFT_LEN - GUARD_SC))
                   && (sc_q[1:0] == v_i);

    // hard QPSK decision, a negative component demodulates to bit 1
    assign re_neg = beat_i.sample.iq.re[IQ_W-1];
    assign im_neg = beat_i.sample.iq.im[IQ_W-1];

    // strict compare keeps the lowest index on a tie
    always_comb begin
        best_idx  = '0;
        best_corr = corr_q[0];
        for (int k = 1; k < NUM_IBAR; k++) begin
            if (corr_q[k] > best_corr) begin
                best_corr = corr_q[k];
                best_idx  = ibar_t'(k);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            busy_q       <= 1'b0;
            sc_q         <= '0;
            pilot_q      <= '0;
            ibar_q       <= '0;
            ibar_valid_q <= 1'b0;
            for (int k = 0; k < NUM_IBAR; k++) begin
                corr_q[k] <= '0;
            end
        end else begin
            ibar_valid_q <= 1'b0;
            if (start) begin
                busy_q  <= 1'b1;
                sc_q    <= SC_W'(1);
                pilot_q <= '0;
            end else if (busy_q && beat_take_i) begin
                sc_q <= sc_q + 1'b1;
                if (is_pilot) begin
                    pilot_q <= pilot_q + 1'b1;
                    for (int k = 0; k < NUM_IBAR; k++) begin
                        corr_q[k] <= corr_q[k] + corr_t'(row_i[k][1] == re_neg)
                                               + corr_t'(row_i[k][0] == im_neg);
                    end
                end
                // pilots end at subcarrier 247, so the counts are final here
                if (last_sc) begin
                    busy_q       <= 1'b0;
                    ibar_q       <= best_idx;
                    ibar_valid_q <= 1'b1;
                    for (int k = 0; k < NUM_IBAR; k++) begin
                        corr_q[k] <= '0;
                    end
                end
            end
        end
    end

    assign rd_idx_o     = pilot_q;
    assign ibar_o       = ibar_q;
    assign ibar_valid_o = ibar_valid_q;

endmodule

// ==== logic/sample_fifo.sv ====
module sample_fifo (
    input  logic               clk_i,
    input  logic               reset_ni,
    input  chest_pkg::stream_t wr_i,
    input  logic               wr_valid_i,
    output logic               wr_ready_o,
    output chest_pkg::stream_t rd_o,
    output logic               rd_valid_o,
    input  logic               rd_ready_i
);
    import chest_pkg::*;

    // the sample word is kept raw next to its start flag
    logic [SAMPLE_W:0]  mem_q [FIFO_DEPTH];
    logic [SAMPLE_W:0]  rd_word;
    logic [FIFO_AW:0]   wr_ptr_q;
    logic [FIFO_AW:0]   rd_ptr_q;
    logic               full;
    logic               empty;
    logic               push;
    logic               pop;

    // the extra pointer bit tells a full buffer from an empty one
    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[FIFO_AW] != rd_ptr_q[FIFO_AW])
                && (wr_ptr_q[FIFO_AW-1:0] == rd_ptr_q[FIFO_AW-1:0]);

    assign push = wr_valid_i && !full;
    assign pop  = rd_ready_i && !empty;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q[FIFO_AW-1:0]] <= {wr_i.sample.raw, wr_i.pbch_start};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    assign rd_word           = mem_q[rd_ptr_q[FIFO_AW-1:0]];
    assign rd_o.sample.raw   = rd_word[SAMPLE_W:1];
    assign rd_o.pbch_start   = rd_word[0];
    assign rd_valid_o        = !empty;
    assign wr_ready_o        = !full;

endmodule

// ==== logic/symbol_release.sv ====
module symbol_release (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  chest_pkg::stream_t   in_i,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  chest_pkg::ibar_t     ibar_i,
    input  logic                 ibar_valid_i,
    output chest_pkg::out_beat_t out_o,
    output logic                 out_valid_o,
    input  logic                 out_ready_i
);
    import chest_pkg::*;

    // detection results that wait for their PBCH start beat
    ibar_t      pend_q [2];
    logic       wr_sel_q;
    logic       rd_sel_q;
    logic [1:0] pend_cnt_q;
    ibar_t      cur_q;
    ibar_t      tag_ibar;
    out_beat_t  out_q;
    logic       out_valid_q;
    logic       out_free;
    logic       have_result;
    logic       take;
    logic       pop;

    assign out_free    = !out_valid_q || out_ready_i;
    assign have_result = (pend_cnt_q != 2'd0);
    // a PBCH start beat stays at the head until its result exists
    assign in_ready_o  = out_free && (!in_i.pbch_start || have_result);
    assign take        = in_valid_i && in_ready_o;
    assign pop         = take && in_i.pbch_start;
    assign tag_ibar    = in_i.pbch_start ? pend_q[rd_sel_q] : cur_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_sel_q    <= 1'b0;
            rd_sel_q    <= 1'b0;
            pend_cnt_q  <= '0;
            cur_q       <= '0;
            out_valid_q <= 1'b0;
        end else begin
            if (ibar_valid_i) begin
                wr_sel_q <= !wr_sel_q;
            end
            if (pop) begin
                rd_sel_q <= !rd_sel_q;
                cur_q    <= pend_q[rd_sel_q];
            end
            pend_cnt_q <= pend_cnt_q + {1'b0, ibar_valid_i} - {1'b0, pop};
            if (out_free) begin
                out_valid_q <= take;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ibar_valid_i) begin
            pend_q[wr_sel_q] <= ibar_i;
        end
        if (take) begin
            out_q <= {in_i, tag_ibar};
        end
    end

    assign out_o       = out_q;
    assign out_valid_o = out_valid_q;

endmodule

// ==== logic/channel_estimator.sv ====
module channel_estimator (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  chest_pkg::stream_t   in_i,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  chest_pkg::n_id_t     n_id_i,
    input  logic                 n_id_valid_i,
    output chest_pkg::out_beat_t out_o,
    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output logic                 dmrs_ready_o,
    output chest_pkg::ibar_t     ibar_o,
    output logic                 ibar_valid_o
);
    import chest_pkg::*;

    dmrs_row_t  dmrs_row;
    logic [7:0] dmrs_rd_idx;
    logic [1:0] dmrs_v;
    stream_t    fifo_rd;
    logic       fifo_rd_valid;
    logic       fifo_rd_ready;

    pbch_dmrs_gen i_pbch_dmrs_gen (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .n_id_i       (n_id_i),
        .n_id_valid_i (n_id_valid_i),
        .rd_idx_i     (dmrs_rd_idx),
        .row_o        (dmrs_row),
        .dmrs_ready_o (dmrs_ready_o),
        .v_o          (dmrs_v)
    );

    // the detector only observes accepted input beats
    ibar_detector i_ibar_detector (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .beat_i       (in_i),
        .beat_take_i  (in_valid_i && in_ready_o),
        .dmrs_ready_i (dmrs_ready_o),
        .v_i          (dmrs_v),
        .rd_idx_o     (dmrs_rd_idx),
        .row_i        (dmrs_row),
        .ibar_o       (ibar_o),
        .ibar_valid_o (ibar_valid_o)
    );

    sample_fifo i_sample_fifo (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .wr_i       (in_i),
        .wr_valid_i (in_valid_i),
        .wr_ready_o (in_ready_o),
        .rd_o       (fifo_rd),
        .rd_valid_o (fifo_rd_valid),
        .rd_ready_i (fifo_rd_ready)
    );

    symbol_release i_symbol_release (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .in_i         (fifo_rd),
        .in_valid_i   (fifo_rd_valid),
        .in_ready_o   (fifo_rd_ready),
        .ibar_i       (ibar_o),
        .ibar_valid_i (ibar_valid_o),
        .out_o        (out_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i)
    );

endmodule

// ==== dv/channel_estimator_checker.sv ====
module channel_estimator_checker (
    input logic                 clk_i,
    input logic                 reset_ni,
    input chest_pkg::stream_t   in_i,
    input logic                 in_valid_i,
    input logic                 in_ready_o,
    input logic                 n_id_valid_i,
    input chest_pkg::out_beat_t out_o,
    input logic                 out_valid_o,
    input logic                 out_ready_i,
    input logic                 dmrs_ready_o,
    input logic                 ibar_valid_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import chest_pkg::*;

    int unsigned fail_cnt = 0;
    logic        take;
    logic        out_take;
    logic        last_take;
    // subcarriers of the current PBCH symbol seen so far, FFT_LEN while the detector is idle
    logic [8:0]  sc_seen_q;
    // beats inside the DUT, FIFO entries plus the output register
    int          held_q;

    assign take      = in_valid_i && in_ready_o;
    assign out_take  = out_valid_o && out_ready_i;
    assign last_take = take && (sc_seen_q == 9'(FFT_LEN - 1));

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sc_seen_q <= 9'(FFT_LEN);
            held_q    <= 0;
        end else begin
            if (take && in_i.pbch_start && dmrs_ready_o && (sc_seen_q == 9'(FFT_LEN))) begin
                sc_seen_q <= 9'd1;
            end else if (take && (sc_seen_q != 9'(FFT_LEN))) begin
                sc_seen_q <= sc_seen_q + 1'b1;
            end
            held_q <= held_q + int'(take) - int'(out_take);
        end
    end

    reset_values: assert property (@(posedge clk_i)
        !reset_ni |=> !out_valid_o && !ibar_valid_o && !dmrs_ready_o && in_ready_o)
    else begin
        fail_cnt++;
        $error("outputs are not at their reset values after reset");
    end

    out_stable: assert property (@(posedge clk_i) disable iff (!reset_ni)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o))
    else begin
        fail_cnt++;
        $error("output beat changed or dropped while out_ready_i was low");
    end

    in_hold: assert property (@(posedge clk_i) disable iff (!reset_ni)
        in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_i))
    else begin
        fail_cnt++;
        $error("input beat changed before it was accepted");
    end

    start_allowed: assert property (@(posedge clk_i) disable iff (!reset_ni)
        take && in_i.pbch_start |-> dmrs_ready_o && (sc_seen_q == 9'(FFT_LEN)))
    else begin
        fail_cnt++;
        $error("PBCH start accepted without DMRS ready or while the detector was busy");
    end

    ibar_on_time: assert property (@(posedge clk_i) disable iff (!reset_ni)
        last_take |=> ibar_valid_o)
    else begin
        fail_cnt++;
        $error("ibar_valid_o did not follow the last subcarrier of a PBCH symbol");
    end

    ibar_only_then: assert property (@(posedge clk_i) disable iff (!reset_ni)
        !last_take |=> !ibar_valid_o)
    else begin
        fail_cnt++;
        $error("ibar_valid_o pulsed without a finished PBCH symbol");
    end

    dmrs_drop: assert property (@(posedge clk_i) disable iff (!reset_ni)
        n_id_valid_i |=> !dmrs_ready_o)
    else begin
        fail_cnt++;
        $error("dmrs_ready_o stayed high after a new cell identity");
    end

    ready_only_full: assert property (@(posedge clk_i) disable iff (!reset_ni)
        !in_ready_o |-> held_q >= FIFO_DEPTH)
    else begin
        fail_cnt++;
        $error("in_ready_o low while the FIFO was not full");
    end

    no_overflow: assert property (@(posedge clk_i) disable iff (!reset_ni)
        held_q <= FIFO_DEPTH + 1)
    else begin
        fail_cnt++;
        $error("more beats accepted than the DUT can hold");
    end

endmodule

// ==== dv/channel_estimator_tb.sv ====
module channel_estimator_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import chest_pkg::*;

    localparam logic [31:0]        SEED          = 32'heda8_7c02;
    localparam int                 NUM_CELLS     = 3;
    localparam int                 SYMS_PER_CELL = 2 * NUM_IBAR;
    // the extra identity is the one dropped during warm-up
    localparam int                 CYCLE_LIMIT   = 2000 * (NUM_CELLS + 1)
                                                 + 600 * NUM_CELLS * SYMS_PER_CELL;
    localparam int                 SEQ_LEN       = GOLD_NC + 2 * DMRS_LEN + GOLD_N;
    localparam logic signed [15:0] PILOT_AMP     = 16'sd8192;
    // long enough for a full FIFO plus the output register at one beat per cycle
    localparam int                 STALL_CYCLES  = 2 * FIFO_DEPTH;

    logic      clk_i;
    logic      reset_ni;
    stream_t   in_i;
    logic      in_valid_i;
    logic      in_ready_o;
    n_id_t     n_id_i;
    logic      n_id_valid_i;
    out_beat_t out_o;
    logic      out_valid_o;
    logic      out_ready_i;
    logic      dmrs_ready_o;
    ibar_t     ibar_o;
    logic      ibar_valid_o;

    logic [31:0] stim_rng  = SEED;
    logic [31:0] ready_rng = ~SEED;
    int          cycle_cnt = 0;
    int          stall_cnt = 0;
    logic        stall_req;
    logic        saw_full;
    ibar_t       last_ibar;
    out_beat_t   want;
    ibar_t       want_ibar;
    out_beat_t   exp_q [$];
    ibar_t       ibar_q [$];

    channel_estimator i_channel_estimator (.*);

    bind channel_estimator channel_estimator_checker i_checker (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .in_i         (in_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .n_id_valid_i (n_id_valid_i),
        .out_o        (out_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .dmrs_ready_o (dmrs_ready_o),
        .ibar_valid_o (ibar_valid_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string why);
        $display("Error at %0t: %s", $time, why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
        $display("SIMULATION FAILED");
        $fatal(1, "value mismatch");
    endtask

    // x2 start value of the Gold generator for one cell identity and ibar_SSB
    function automatic logic [GOLD_N-1:0] x2_start(input n_id_t n_id, input ibar_t ibar);
        int unsigned c_init;
        c_init = ((int'(ibar) + 1) * (int'(n_id) / 4 + 1)) * 2048
               + (int'(ibar) + 1) * 64 + int'(n_id) % 4;
        return GOLD_N'(c_init);
    endfunction

    // bit n of the result is c(n) of the length-31 Gold sequence
    function automatic logic [2*DMRS_LEN-1:0] dmrs_bits(input logic [GOLD_N-1:0] c_init);
        logic                  x1 [SEQ_LEN];
        logic                  x2 [SEQ_LEN];
        logic [2*DMRS_LEN-1:0] c;
        logic                  f1;
        logic                  f2;
        for (int n = 0; n < GOLD_N; n++) begin
            x1[n] = (n == 0);
            x2[n] = c_init[n];
        end
        for (int n = 0; n + GOLD_N < SEQ_LEN; n++) begin
            f1 = 1'b0;
            f2 = 1'b0;
            for (int k = 0; k < GOLD_N; k++) begin
                f1 = f1 ^ (X1_TAPS[k] & x1[n + k]);
                f2 = f2 ^ (X2_TAPS[k] & x2[n + k]);
            end
            x1[n + GOLD_N] = f1;
            x2[n + GOLD_N] = f2;
        end
        for (int n = 0; n < 2 * DMRS_LEN; n++) begin
            c[n] = x1[n + GOLD_NC] ^ x2[n + GOLD_NC];
        end
        return c;
    endfunction

    task automatic send_beat(input stream_t beat, input ibar_t tag);
        out_beat_t exp_beat;
        in_i       <= beat;
        in_valid_i <= 1'b1;
        @(posedge clk_i);
        while (!in_ready_o) begin
            @(posedge clk_i);
        end
        exp_beat.beat = beat;
        exp_beat.ibar = tag;
        exp_q.push_back(exp_beat);
    endtask

    task automatic send_symbol(input n_id_t n_id, input logic pbch, input ibar_t ibar);
        logic [2*DMRS_LEN-1:0] seq;
        stream_t               beat;
        int                    m;
        m   = 0;
        seq = '0;
        if (pbch) begin
            seq       = dmrs_bits(x2_start(n_id, ibar));
            last_ibar = ibar;
            ibar_q.push_back(ibar);
        end
        for (int sc = 0; sc < FFT_LEN; sc++) begin
            stim_rng          = xorshift32(stim_rng);
            beat.sample.raw   = stim_rng;
            beat.pbch_start   = pbch && (sc == 0);
            if (pbch && sc >= GUARD_SC && sc < FFT_LEN - GUARD_SC
                    && sc % 4 == int'(n_id[1:0]) && m < PILOTS_PER_SYM) begin
                beat.sample.iq.re = seq[2*m] ? -PILOT_AMP : PILOT_AMP;
                beat.sample.iq.im = seq[2*m+1] ? -PILOT_AMP : PILOT_AMP;
                m++;
            end
            send_beat(beat, last_ibar);
        end
    endtask

    task automatic pulse_n_id(input n_id_t n_id);
        n_id_i       <= n_id;
        n_id_valid_i <= 1'b1;
        @(posedge clk_i);
        n_id_valid_i <= 1'b0;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            abort_run("timeout, the DUT stopped making progress");
        end
    end

    initial begin
        wait (i_channel_estimator.i_checker.fail_cnt != 0);
        abort_run("a concurrent assertion in the checker failed");
    end

    // random low cycles on out_ready_i, and one bounded stall that should fill the FIFO
    always @(posedge clk_i) begin
        ready_rng = xorshift32(ready_rng);
        if (stall_req && !saw_full && stall_cnt < STALL_CYCLES) begin
            stall_cnt   <= stall_cnt + 1;
            out_ready_i <= 1'b0;
            if (!in_ready_o) begin
                saw_full <= 1'b1;
            end
        end else begin
            out_ready_i <= (ready_rng[1:0] != 2'b00);
        end
    end

    always @(posedge clk_i) begin
        if (reset_ni && out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                abort_run("output beat with no matching input beat");
            end else begin
                want = exp_q.pop_front();
                assert (out_o == want) else value_error("out_o", want, out_o);
            end
        end
        if (reset_ni && ibar_valid_o) begin
            if (ibar_q.size() == 0) begin
                abort_run("ibar_valid_o pulse with no PBCH symbol sent");
            end else begin
                want_ibar = ibar_q.pop_front();
                assert (ibar_o == want_ibar) else value_error("ibar_o", want_ibar, ibar_o);
            end
        end
    end

    initial begin
        n_id_t n_id;
        ibar_t offset;
        reset_ni     = 1'b0;
        in_i         = '0;
        in_valid_i   = 1'b0;
        n_id_i       = '0;
        n_id_valid_i = 1'b0;
        out_ready_i  = 1'b1;
        stall_req    = 1'b0;
        saw_full     = 1'b0;
        last_ibar    = '0;
        repeat (8) @(posedge clk_i);
        reset_ni <= 1'b1;
        @(posedge clk_i);
        for (int r = 0; r < NUM_CELLS; r++) begin
            stim_rng = xorshift32(stim_rng);
            n_id     = n_id_t'(stim_rng % 1008);
            if (r == 0) begin
                // this identity is replaced part way through its warm-up
                pulse_n_id(n_id_t'((stim_rng >> 10) % 1008));
                repeat (300) @(posedge clk_i);
            end
            pulse_n_id(n_id);
            @(posedge clk_i);
            while (!dmrs_ready_o) begin
                @(posedge clk_i);
            end
            if (r == NUM_CELLS - 1) begin
                stall_req <= 1'b1;
            end
            stim_rng = xorshift32(stim_rng);
            offset   = stim_rng[2:0];
            for (int k = 0; k < NUM_IBAR; k++) begin
                send_symbol(n_id, 1'b1, ibar_t'(k + int'(offset)));
                send_symbol(n_id, 1'b0, '0);
            end
            in_valid_i <= 1'b0;
            while (exp_q.size() != 0 || ibar_q.size() != 0) begin
                @(posedge clk_i);
            end
        end
        if (saw_full) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run("in_ready_o never fell while the output was stalled");
        end
    end

endmodule

// ==== flist.f ====
logic/chest_pkg.sv
logic/gold_lfsr.sv
logic/pbch_dmrs_gen.sv
logic/ibar_detector.sv
logic/sample_fifo.sv
logic/symbol_release.sv
logic/channel_estimator.sv
dv/channel_estimator_checker.sv
dv/channel_estimator_tb.sv
